//--- bench/tb_lpif_adapter.sv
/*
 * link adapter testbench
 * clock and reset, galois lfsr stimulus, stream and protocol id reference maps,
 * downstream compare process against an expected flit queue, per-test report
 */
`timescale 1ns/1ns
`include "lpif_defs.svh"

module tb_lpif_adapter;

  localparam int DW      = `LPIF_DATA_BYTES * 8;
  localparam int CW      = `LPIF_CRC_WIDTH;
  localparam int ENT_W   = DW + CW + 3;
  // wait conditions
  localparam int C_MAC_RDY    = 0;
  localparam int C_RSTN       = 1;
  localparam int C_ANY_ONLINE = 2;
  localparam int C_ONLINE     = 3;
  localparam int C_LINK_UP    = 4;
  localparam int C_TRDY       = 5;
  localparam int C_DRAINED    = 6;

  logic                  com_clk;
  logic                  rst_n;
  logic                  i_conf_done;
  logic [`AIB_LANES-1:0] ms_tx_transfer_en;
  logic [`AIB_LANES-1:0] sl_tx_transfer_en;
  logic                  align_done;
  logic                  ns_mac_rdy;
  logic [`AIB_LANES-1:0] ns_adapter_rstn;
  logic                  tx_online;
  logic                  rx_online;
  logic                  link_up;
  logic                  lp_irdy;
  logic                  lp_valid;
  logic [7:0]            lp_stream;
  logic [DW-1:0]         lp_data;
  logic [CW-1:0]         lp_crc;
  logic                  lp_crc_valid;
  logic                  pl_trdy;
  logic [7:0]            acc_count;
  logic                  aib_tx_hold;
  logic                  dstrm_valid;
  logic [1:0]            dstrm_protid;
  logic [DW-1:0]         dstrm_data;
  logic [CW-1:0]         dstrm_crc;
  logic                  dstrm_crc_valid;
  logic                  ustrm_valid;
  logic [1:0]            ustrm_protid;
  logic [DW-1:0]         ustrm_data;
  logic [CW-1:0]         ustrm_crc;
  logic                  ustrm_crc_valid;
  logic                  pl_valid;
  logic [7:0]            pl_stream;
  logic [DW-1:0]         pl_data;
  logic [CW-1:0]         pl_crc;
  logic                  pl_crc_valid;

  logic [31:0]      lfsr_state;
  logic [ENT_W-1:0] exp_q[$];
  logic [ENT_W-1:0] head;
  int               pass_count;
  int               fail_count;
  int               recv_count;
  int               errs;
  int               base;
  logic [7:0]       s5;
  logic [DW-1:0]    d5;
  logic [CW-1:0]    c5;
  logic             v5;
  logic             prev_valid;
  logic [1:0]       prev_protid;
  logic [DW-1:0]    prev_data;
  logic [CW-1:0]    prev_crc;
  logic             prev_crcv;

  lpif_adapter_top u_lpif_adapter_top (.*);

  initial begin
    com_clk = 1'b0;
    forever #4 com_clk = ~com_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference maps
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], rand_bit()};
    return v;
  endfunction

  // unknown streams travel as mem-cache
  function automatic logic [1:0] stream_to_protid(input logic [7:0] s);
    case (s)
      `MEM_CACHE_STREAM_ID: return 2'd0;
      `IO_STREAM_ID:        return 2'd1;
      `ARB_MUX_STREAM_ID:   return 2'd2;
      default:              return 2'd0;
    endcase
  endfunction

  function automatic logic [7:0] protid_to_stream(input logic [1:0] p);
    case (p)
      2'd1:    return `IO_STREAM_ID;
      2'd2:    return `ARB_MUX_STREAM_ID;
      default: return `MEM_CACHE_STREAM_ID;
    endcase
  endfunction

  function automatic bit cond_met(input int cond);
    case (cond)
      C_MAC_RDY:    return ns_mac_rdy === 1'b1;
      C_RSTN:       return ns_adapter_rstn === {`AIB_LANES{1'b1}};
      C_ANY_ONLINE: return (tx_online | rx_online) === 1'b1;
      C_ONLINE:     return (tx_online & rx_online) === 1'b1;
      C_LINK_UP:    return link_up === 1'b1;
      C_TRDY:       return pl_trdy === 1'b1;
      C_DRAINED:    return exp_q.size() == 0;
      default:      return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // check and stimulus tasks, all entered and left at posedge + 1
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic wait_until(input int cond, input string what, input int limit,
                            input bit rand_hold);
    int  n;
    bit  met;
    n   = 0;
    met = 1'b0;
    while (!met && n < limit) begin
      @(negedge com_clk);
      met = cond_met(cond);
      @(posedge com_clk);
      #1;
      if (rand_hold) aib_tx_hold = rand_bit();
      n++;
    end
    if (!met) begin
      $display("timeout after %0d cycles waiting for %s", limit, what);
      fail_count++;
    end
  endtask

  task automatic expect_absent(input int cond, input string what, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge com_clk);
      if (cond_met(cond)) begin
        $display("unexpected %s", what);
        fail_count++;
      end else begin
        pass_count++;
      end
      @(posedge com_clk);
      #1;
    end
  endtask

  task automatic drive_flit(input logic [7:0] s, input logic [DW-1:0] d,
                            input logic [CW-1:0] c, input logic v);
    lp_irdy      = 1'b1;
    lp_valid     = 1'b1;
    lp_stream    = s;
    lp_data      = d;
    lp_crc       = c;
    lp_crc_valid = v;
  endtask

  // offer one flit until the edge that accepts it
  task automatic send_flit(input logic [7:0] s, input logic [DW-1:0] d,
                           input logic [CW-1:0] c, input logic v, input bit rand_hold);
    int n;
    bit accepted;
    n        = 0;
    accepted = 1'b0;
    drive_flit(s, d, c, v);
    while (!accepted && n < 50) begin
      @(negedge com_clk);
      accepted = (pl_trdy === 1'b1);
      @(posedge com_clk);
      #1;
      if (rand_hold) aib_tx_hold = rand_bit();
      n++;
    end
    if (accepted) begin
      exp_q.push_back({stream_to_protid(s), v, c, d});
    end else begin
      $display("timeout, flit on stream %h was never accepted", s);
      fail_count++;
    end
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
  endtask

  task automatic send_random_flit(input bit rand_hold);
    logic [7:0]    s;
    logic [DW-1:0] d;
    logic [CW-1:0] c;
    logic          v;
    // three stream bits, so unknown ids show up too
    s = 8'(rand_bits(3));
    d = DW'(rand_bits(DW));
    c = CW'(rand_bits(CW));
    v = rand_bit();
    send_flit(s, d, c, v, rand_hold);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (fail_count == errs_before) $display("%s: finished, no errors", name);
    else $display("%s: finished, %0d errors", name, fail_count - errs_before);
  endtask

  // every downstream pulse against the head of the expected queue
  always @(negedge com_clk) begin
    if (rst_n === 1'b1 && dstrm_valid === 1'b1) begin
      recv_count++;
      if (exp_q.size() == 0) begin
        $display("flit on the downstream bus with none expected");
        fail_count++;
      end else begin
        head = exp_q.pop_front();
        check_value("dstrm_protid", 64'(dstrm_protid), 64'(head[DW+CW+2:DW+CW+1]));
        check_value("dstrm_crc_valid", 64'(dstrm_crc_valid), 64'(head[DW+CW]));
        check_value("dstrm_crc", 64'(dstrm_crc), 64'(head[DW+CW-1:DW]));
        check_value("dstrm_data", 64'(dstrm_data), 64'(head[DW-1:0]));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_state = 32'h6b53;
    pass_count = 0;
    fail_count = 0;
    recv_count = 0;
    rst_n = 1'b0;
    i_conf_done = 1'b0;
    ms_tx_transfer_en = '0;
    sl_tx_transfer_en = '0;
    align_done = 1'b0;
    lp_irdy = 1'b0;
    lp_valid = 1'b0;
    lp_stream = '0;
    lp_data = '0;
    lp_crc = '0;
    lp_crc_valid = 1'b0;
    aib_tx_hold = 1'b0;
    ustrm_valid = 1'b0;
    ustrm_protid = '0;
    ustrm_data = '0;
    ustrm_crc = '0;
    ustrm_crc_valid = 1'b0;
    repeat (2) @(posedge com_clk);
    #1;
    rst_n = 1'b1;

    // bring-up order
    errs = fail_count;
    @(negedge com_clk);
    check_value("ns_mac_rdy", 64'(ns_mac_rdy), 64'd0);
    check_value("ns_adapter_rstn", 64'(ns_adapter_rstn), 64'd0);
    check_value("tx_online", 64'(tx_online), 64'd0);
    check_value("rx_online", 64'(rx_online), 64'd0);
    check_value("link_up", 64'(link_up), 64'd0);
    check_value("pl_trdy", 64'(pl_trdy), 64'd0);
    check_value("dstrm_valid", 64'(dstrm_valid), 64'd0);
    check_value("pl_valid", 64'(pl_valid), 64'd0);
    @(posedge com_clk);
    #1;
    expect_absent(C_MAC_RDY, "ns_mac_rdy before i_conf_done", 6);
    i_conf_done = 1'b1;
    wait_until(C_MAC_RDY, "ns_mac_rdy", 20, 1'b0);
    wait_until(C_RSTN, "ns_adapter_rstn all high", 20, 1'b0);
    ms_tx_transfer_en = 4'hB;
    sl_tx_transfer_en = '1;
    expect_absent(C_ANY_ONLINE, "tx/rx online with a leader lane not enabled", 3);
    ms_tx_transfer_en = '1;
    sl_tx_transfer_en = 4'h7;
    expect_absent(C_ANY_ONLINE, "tx/rx online with a follower lane not enabled", 3);
    sl_tx_transfer_en = '1;
    wait_until(C_ONLINE, "tx_online and rx_online", 20, 1'b0);
    expect_absent(C_LINK_UP, "link_up before align_done", 4);
    report_test("bring-up", errs);

    // nothing accepted before link up
    errs = fail_count;
    drive_flit(`IO_STREAM_ID, DW'(rand_bits(DW)), CW'(rand_bits(CW)), 1'b1);
    expect_absent(C_TRDY, "pl_trdy before link_up", 8);
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
    @(negedge com_clk);
    check_value("acc_count", 64'(acc_count), 64'd0);
    @(posedge com_clk);
    #1;
    align_done = 1'b1;
    wait_until(C_LINK_UP, "link_up", 20, 1'b0);
    report_test("gating", errs);

    // mapping and order, no hold
    errs = fail_count;
    base = recv_count;
    for (int i = 0; i < 16; i++) send_random_flit(1'b0);
    wait_until(C_DRAINED, "sixteen downstream flits", 40, 1'b0);
    @(negedge com_clk);
    check_value("acc_count", 64'(acc_count), 64'd16);
    check_value("flits received", 64'(recv_count - base), 64'd16);
    @(posedge com_clk);
    #1;
    report_test("downstream order", errs);

    // fill the queue under hold, then drain with a random hold pattern
    errs = fail_count;
    base = recv_count;
    aib_tx_hold = 1'b1;
    for (int i = 0; i < `FLIT_FIFO_DEPTH; i++) send_random_flit(1'b0);
    s5 = 8'(rand_bits(3));
    d5 = DW'(rand_bits(DW));
    c5 = CW'(rand_bits(CW));
    v5 = rand_bit();
    drive_flit(s5, d5, c5, v5);
    expect_absent(C_TRDY, "pl_trdy with the queue full", 6);
    @(negedge com_clk);
    check_value("flits received under hold", 64'(recv_count - base), 64'd0);
    @(posedge com_clk);
    #1;
    send_flit(s5, d5, c5, v5, 1'b1);
    send_random_flit(1'b1);
    wait_until(C_DRAINED, "flits held back", 80, 1'b1);
    aib_tx_hold = 1'b0;
    @(negedge com_clk);
    check_value("flits received", 64'(recv_count - base), 64'(`FLIT_FIFO_DEPTH + 2));
    check_value("acc_count", 64'(acc_count), 64'(16 + `FLIT_FIFO_DEPTH + 2));
    @(posedge com_clk);
    #1;
    report_test("back-pressure", errs);

    // upstream register, one flit per cycle, checked a cycle later
    errs = fail_count;
    prev_valid = 1'b0;
    prev_protid = '0;
    prev_data = '0;
    prev_crc = '0;
    prev_crcv = 1'b0;
    for (int i = 0; i <= 12; i++) begin
      if (i < 12) begin
        ustrm_valid     = rand_bit();
        ustrm_protid    = (i == 0) ? 2'd3 : 2'(rand_bits(2));
        ustrm_data      = DW'(rand_bits(DW));
        ustrm_crc       = CW'(rand_bits(CW));
        ustrm_crc_valid = rand_bit();
      end else begin
        ustrm_valid = 1'b0;
      end
      @(negedge com_clk);
      if (i > 0) begin
        check_value("pl_valid", 64'(pl_valid), 64'(prev_valid));
        check_value("pl_stream", 64'(pl_stream), 64'(protid_to_stream(prev_protid)));
        check_value("pl_data", 64'(pl_data), 64'(prev_data));
        check_value("pl_crc", 64'(pl_crc), 64'(prev_crc));
        check_value("pl_crc_valid", 64'(pl_crc_valid), 64'(prev_crcv));
      end
      prev_valid  = ustrm_valid;
      prev_protid = ustrm_protid;
      prev_data   = ustrm_data;
      prev_crc    = ustrm_crc;
      prev_crcv   = ustrm_crc_valid;
      @(posedge com_clk);
      #1;
    end
    report_test("upstream", errs);

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the link adapter simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f sim.f \
  --top-module tb_lpif_adapter -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

//--- sim.f
+incdir+verilog
verilog/lpif_flit_pkg.sv
verilog/lpif_ctl_pkg.sv
verilog/flit_if.sv
verilog/lpif_ctl.sv
verilog/dstrm_encoder.sv
verilog/flit_fifo.sv
verilog/dstrm_emitter.sv
verilog/lpif_adapter_top.sv
bench/tb_lpif_adapter.sv

//--- verilog/dstrm_emitter.sv
/*
 * downstream flit emitter
 * pops the queue head and registers it onto the aib downstream bus
 */
`timescale 1ns/1ns

module dstrm_emitter import lpif_flit_pkg::*; (
  input  logic       com_clk,
  input  logic       rst_n,
  input  logic       tx_online,
  input  logic       aib_tx_hold,
  flit_if.pop_dst    pop,
  output logic       dstrm_valid,
  output protid_e    dstrm_protid,
  output flit_data_t dstrm_data,
  output flit_crc_t  dstrm_crc,
  output logic       dstrm_crc_valid
);

  // take the head whenever tx is online and the far side is not holding
  assign pop.stb = pop.avail & tx_online & ~aib_tx_hold;

  // one pulse per flit
  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_valid <= 1'b0;
    end else begin
      dstrm_valid <= pop.stb;
    end
  end

  // fields keep the last flit between pops
  always_ff @(posedge com_clk) begin
    if (pop.stb) begin
      dstrm_protid    <= pop.protid;
      dstrm_data      <= pop.data;
      dstrm_crc       <= pop.crc;
      dstrm_crc_valid <= pop.crc_valid;
    end
  end

endmodule

//--- verilog/dstrm_encoder.sv
/*
 * downstream flit encoder
 * link-layer acceptance, stream to protocol id mapping,
 * push into the flit queue and accepted flit counter
 */
`timescale 1ns/1ns
`include "lpif_defs.svh"

module dstrm_encoder import lpif_flit_pkg::*; (
  input  logic       com_clk,
  input  logic       rst_n,
  input  logic       link_up,
  input  logic       lp_irdy,
  input  logic       lp_valid,
  input  logic [7:0] lp_stream,
  input  flit_data_t lp_data,
  input  flit_crc_t  lp_crc,
  input  logic       lp_crc_valid,
  output logic       pl_trdy,
  output logic [7:0] acc_count,
  flit_if.push_src   push
);

  protid_e lp_protid;
  logic    accept;

  // unknown streams are sent as mem-cache
  always_comb begin
    case (lp_stream)
      `MEM_CACHE_STREAM_ID: lp_protid = protid_cache;
      `IO_STREAM_ID:        lp_protid = protid_io;
      `ARB_MUX_STREAM_ID:   lp_protid = protid_arb_mux;
      default:              lp_protid = protid_cache;
    endcase
  end

  // ready only with the link up and space in the queue
  assign pl_trdy = link_up & push.room;
  assign accept  = lp_irdy & lp_valid & pl_trdy;

  // push on the accepting edge
  assign push.stb       = accept;
  assign push.data      = lp_data;
  assign push.crc       = lp_crc;
  assign push.crc_valid = lp_crc_valid;
  assign push.protid    = lp_protid;

  // status, wraps after 255
  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_count <= 8'd0;
    end else if (accept) begin
      acc_count <= acc_count + 8'd1;
    end
  end

endmodule

//--- verilog/flit_fifo.sv
/*
 * flit queue
 * first-word-fall-through circular buffer, simultaneous push and pop
 */
`timescale 1ns/1ns
`include "lpif_defs.svh"

module flit_fifo import lpif_flit_pkg::*; (
  input  logic     com_clk,
  input  logic     rst_n,
  flit_if.push_dst wr,
  flit_if.pop_src  rd
);

  localparam int PTR_W = $clog2(`FLIT_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FLIT_FIFO_DEPTH + 1);

  flit_data_t       data_mem   [`FLIT_FIFO_DEPTH];
  flit_crc_t        crc_mem    [`FLIT_FIFO_DEPTH];
  logic             crcv_mem   [`FLIT_FIFO_DEPTH];
  protid_e          protid_mem [`FLIT_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             room;
  logic             avail;

  // pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FLIT_FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign push  = wr.stb;
  assign pop   = rd.stb;
  assign room  = (count != CNT_W'(`FLIT_FIFO_DEPTH));
  assign avail = (count != '0);

  // status goes to both sides
  assign wr.room  = room;
  assign wr.avail = avail;
  assign rd.room  = room;
  assign rd.avail = avail;

  always_ff @(posedge com_clk) begin
    if (push) begin
      data_mem[wr_ptr]   <= wr.data;
      crc_mem[wr_ptr]    <= wr.crc;
      crcv_mem[wr_ptr]   <= wr.crc_valid;
      protid_mem[wr_ptr] <= wr.protid;
    end
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // head entry shown without a read cycle
  assign rd.data      = data_mem[rd_ptr];
  assign rd.crc       = crc_mem[rd_ptr];
  assign rd.crc_valid = crcv_mem[rd_ptr];
  assign rd.protid    = protid_mem[rd_ptr];

endmodule

//--- verilog/flit_if.sv
/*
 * flit transfer interface
 * one flit with its strobe, plus the queue status levels
 */
`timescale 1ns/1ns

interface flit_if import lpif_flit_pkg::*; ();

  // one cycle per flit moved
  logic       stb;
  flit_data_t data;
  flit_crc_t  crc;
  logic       crc_valid;
  protid_e    protid;
  // queue status
  logic       room;
  logic       avail;

  // producer into the queue
  modport push_src (output stb, data, crc, crc_valid, protid, input room);
  // queue write side
  modport push_dst (input stb, data, crc, crc_valid, protid, output room, avail);
  // queue read side, head fields valid while avail
  modport pop_src (input stb, output data, crc, crc_valid, protid, avail, room);
  // consumer out of the queue
  modport pop_dst (output stb, input data, crc, crc_valid, protid, avail);

endinterface

//--- verilog/lpif_adapter_top.sv
/*
 * link adapter top level
 * bring-up controller, downstream encoder, flit queue and emitter
 */
`timescale 1ns/1ns
`include "lpif_defs.svh"

module lpif_adapter_top import lpif_flit_pkg::*; (
  input  logic                  com_clk,
  input  logic                  rst_n,
  // phy and channel alignment
  input  logic                  i_conf_done,
  input  logic [`AIB_LANES-1:0] ms_tx_transfer_en,
  input  logic [`AIB_LANES-1:0] sl_tx_transfer_en,
  input  logic                  align_done,
  output logic                  ns_mac_rdy,
  output logic [`AIB_LANES-1:0] ns_adapter_rstn,
  output logic                  tx_online,
  output logic                  rx_online,
  output logic                  link_up,
  // link layer downstream
  input  logic                  lp_irdy,
  input  logic                  lp_valid,
  input  logic [7:0]            lp_stream,
  input  flit_data_t            lp_data,
  input  flit_crc_t             lp_crc,
  input  logic                  lp_crc_valid,
  output logic                  pl_trdy,
  output logic [7:0]            acc_count,
  // aib downstream
  input  logic                  aib_tx_hold,
  output logic                  dstrm_valid,
  output logic [1:0]            dstrm_protid,
  output flit_data_t            dstrm_data,
  output flit_crc_t             dstrm_crc,
  output logic                  dstrm_crc_valid,
  // aib upstream
  input  logic                  ustrm_valid,
  input  logic [1:0]            ustrm_protid,
  input  flit_data_t            ustrm_data,
  input  flit_crc_t             ustrm_crc,
  input  logic                  ustrm_crc_valid,
  // link layer upstream
  output logic                  pl_valid,
  output logic [7:0]            pl_stream,
  output flit_data_t            pl_data,
  output flit_crc_t             pl_crc,
  output logic                  pl_crc_valid
);

  protid_e emit_protid;

  flit_if push_bus ();
  flit_if pop_bus ();

  lpif_ctl u_lpif_ctl (
    .com_clk           (com_clk),
    .rst_n             (rst_n),
    .i_conf_done       (i_conf_done),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .sl_tx_transfer_en (sl_tx_transfer_en),
    .align_done        (align_done),
    .ustrm_valid       (ustrm_valid),
    .ustrm_protid      (ustrm_protid),
    .ustrm_data        (ustrm_data),
    .ustrm_crc         (ustrm_crc),
    .ustrm_crc_valid   (ustrm_crc_valid),
    .ns_mac_rdy        (ns_mac_rdy),
    .ns_adapter_rstn   (ns_adapter_rstn),
    .tx_online         (tx_online),
    .rx_online         (rx_online),
    .link_up           (link_up),
    .pl_valid          (pl_valid),
    .pl_stream         (pl_stream),
    .pl_data           (pl_data),
    .pl_crc            (pl_crc),
    .pl_crc_valid      (pl_crc_valid)
  );

  dstrm_encoder u_dstrm_encoder (
    .com_clk      (com_clk),
    .rst_n        (rst_n),
    .link_up      (link_up),
    .lp_irdy      (lp_irdy),
    .lp_valid     (lp_valid),
    .lp_stream    (lp_stream),
    .lp_data      (lp_data),
    .lp_crc       (lp_crc),
    .lp_crc_valid (lp_crc_valid),
    .pl_trdy      (pl_trdy),
    .acc_count    (acc_count),
    .push         (push_bus)
  );

  flit_fifo u_flit_fifo (
    .com_clk (com_clk),
    .rst_n   (rst_n),
    .wr      (push_bus),
    .rd      (pop_bus)
  );

  dstrm_emitter u_dstrm_emitter (
    .com_clk         (com_clk),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .aib_tx_hold     (aib_tx_hold),
    .pop             (pop_bus),
    .dstrm_valid     (dstrm_valid),
    .dstrm_protid    (emit_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid)
  );

  // plain two-bit code at the boundary
  assign dstrm_protid = emit_protid;

endmodule

//--- verilog/lpif_ctl.sv
/*
 * link bring-up controller
 * phy init, lane reset release, online and link-up status,
 * upstream flit register with protocol id to stream mapping
 */
`timescale 1ns/1ns
`include "lpif_defs.svh"

module lpif_ctl import lpif_flit_pkg::*, lpif_ctl_pkg::*; (
  input  logic                  com_clk,
  input  logic                  rst_n,
  input  logic                  i_conf_done,
  input  logic [`AIB_LANES-1:0] ms_tx_transfer_en,
  input  logic [`AIB_LANES-1:0] sl_tx_transfer_en,
  input  logic                  align_done,
  input  logic                  ustrm_valid,
  input  logic [1:0]            ustrm_protid,
  input  flit_data_t            ustrm_data,
  input  flit_crc_t             ustrm_crc,
  input  logic                  ustrm_crc_valid,
  output logic                  ns_mac_rdy,
  output logic [`AIB_LANES-1:0] ns_adapter_rstn,
  output logic                  tx_online,
  output logic                  rx_online,
  output logic                  link_up,
  output logic                  pl_valid,
  output logic [7:0]            pl_stream,
  output flit_data_t            pl_data,
  output flit_crc_t             pl_crc,
  output logic                  pl_crc_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // bring-up state machine
  ////////////////////////////////////////////////////////////////////////////

  ctl_state_e            state;
  ctl_state_e            state_nxt;
  logic                  mac_rdy_nxt;
  logic [`AIB_LANES-1:0] adapter_rstn_nxt;
  logic                  online_nxt;
  logic [7:0]            stream_nxt;

  always_comb begin
    state_nxt        = state;
    mac_rdy_nxt      = ns_mac_rdy;
    adapter_rstn_nxt = ns_adapter_rstn;
    online_nxt       = tx_online;
    case (state)
      ctl_idle: begin
        state_nxt = ctl_phy_init;
      end
      ctl_phy_init: begin
        if (i_conf_done) begin
          mac_rdy_nxt = 1'b1;
          state_nxt   = ctl_cfg;
        end
      end
      ctl_cfg: begin
        // release every lane adapter at once
        adapter_rstn_nxt = {`AIB_LANES{1'b1}};
        state_nxt        = ctl_calib;
      end
      ctl_calib: begin
        // wait for both leader and follower tx enables on all lanes
        if (&{ms_tx_transfer_en, sl_tx_transfer_en}) begin
          online_nxt = 1'b1;
          state_nxt  = ctl_wait_ca_align;
        end
      end
      ctl_wait_ca_align: begin
        if (align_done) begin
          state_nxt = ctl_link_up;
        end
      end
      ctl_link_up: begin
        state_nxt = ctl_link_up;
      end
      default: state_nxt = ctl_idle;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= ctl_idle;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
    end else begin
      state           <= state_nxt;
      ns_mac_rdy      <= mac_rdy_nxt;
      ns_adapter_rstn <= adapter_rstn_nxt;
      tx_online       <= online_nxt;
      rx_online       <= online_nxt;
    end
  end

  // link up is held until reset
  assign link_up = (state == ctl_link_up);

  ////////////////////////////////////////////////////////////////////////////
  // upstream flit register
  ////////////////////////////////////////////////////////////////////////////

  // protocol id back to stream, code 3 lands on mem-cache
  always_comb begin
    case (ustrm_protid)
      protid_cache:   stream_nxt = `MEM_CACHE_STREAM_ID;
      protid_io:      stream_nxt = `IO_STREAM_ID;
      protid_arb_mux: stream_nxt = `ARB_MUX_STREAM_ID;
      default:        stream_nxt = `MEM_CACHE_STREAM_ID;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      pl_valid <= 1'b0;
    end else begin
      pl_valid <= ustrm_valid;
    end
  end

  always_ff @(posedge com_clk) begin
    pl_stream    <= stream_nxt;
    pl_data      <= ustrm_data;
    pl_crc       <= ustrm_crc;
    pl_crc_valid <= ustrm_crc_valid;
  end

endmodule

//--- verilog/lpif_ctl_pkg.sv
/*
 * bring-up controller types
 * state encoding of the near-side link bring-up
 */
package lpif_ctl_pkg;

  // phases from phy config up to link up
  typedef enum logic [2:0] {
    ctl_idle          = 3'd0,
    ctl_phy_init      = 3'd1,
    ctl_cfg           = 3'd2,
    ctl_calib         = 3'd3,
    ctl_wait_ca_align = 3'd4,
    ctl_link_up       = 3'd5
  } ctl_state_e;

endpackage

//--- verilog/lpif_defs.svh
/*
 * link adapter constants
 * flit payload and crc widths, flit queue depth,
 * aib lane count and the lpif stream numbers
 */
`ifndef LPIF_DEFS_SVH
`define LPIF_DEFS_SVH

// payload bytes per flit, 64-bit data bus
`define LPIF_DATA_BYTES 8

// crc field for the single-valid mode
`define LPIF_CRC_WIDTH 16

// flit queue entries
`define FLIT_FIFO_DEPTH 4

// aib channels served by this adapter
`define AIB_LANES 4

// lpif stream numbers
`define MEM_CACHE_STREAM_ID 8'h01
`define IO_STREAM_ID 8'h02
`define ARB_MUX_STREAM_ID 8'h03

`endif

//--- verilog/lpif_flit_pkg.sv
/*
 * flit field types
 * protocol id encoding carried on the aib side,
 * payload and crc vector types
 */
`include "lpif_defs.svh"

package lpif_flit_pkg;

  // two-bit protocol id, code 3 unused
  typedef enum logic [1:0] {
    protid_cache   = 2'd0,
    protid_io      = 2'd1,
    protid_arb_mux = 2'd2
  } protid_e;

  // flit payload
  typedef logic [`LPIF_DATA_BYTES*8-1:0] flit_data_t;

  // flit crc
  typedef logic [`LPIF_CRC_WIDTH-1:0] flit_crc_t;

endpackage
